/* logic/i2s_cfg_pkg.sv */
`default_nettype none

package i2s_cfg_pkg;

    //////////////////////////////////////////////////
    // Self-test ramp fields
    //////////////////////////////////////////////////

    localparam int RAMP_VAL_W = 12;                     // Start value and upper limit width
    localparam int RAMP_INC_W = 8;                      // Step width

    typedef logic [RAMP_VAL_W-1:0] ramp_val_t;          // Ramp start or limit
    typedef logic [RAMP_INC_W-1:0] ramp_inc_t;          // Ramp step

    //////////////////////////////////////////////////
    // Default sizing
    //////////////////////////////////////////////////

    localparam int FIFO_DEPTH_LOG2_DEF = 3;             // 8 stereo frames
    localparam int RAMP_PERIOD_DEF     = 64;            // clk cycles per ramp frame

endpackage

`default_nettype wire

/* logic/i2s_deserializer.sv */
`default_nettype none
`timescale 1ns/100ps

module i2s_deserializer import i2s_stream_pkg::*; #(
    parameter int SAMPLE_W = 16                         // Bits per channel word
) (
    input  logic    clk,                                // System clock
    input  logic    rst,                                // Async reset, active low
    input  logic    sck_rise,                           // Bit clock rising edge
    input  logic    ws_s,                               // Synced word select
    input  logic    sd_s,                               // Synced serial data
    input  logic    rx_en,                              // Receiver enable
    output frame_t  rx_frame,                           // Last complete stereo frame
    output logic    rx_strobe                           // Pulse when rx_frame is new
);

typedef enum logic [1:0] {
    ST_IDLE,                                            // Disabled
    ST_WAIT,                                            // Looking for ws 1 to 0
    ST_RUN                                              // Locked to the stream
} state_t;

localparam int CNT_W = $clog2(SAMPLE_W + 1);            // Counts 0 to SAMPLE_W

state_t                 state;
logic                   ws_prev;                        // ws at previous sck_rise
logic                   ws_edge;                        // ws changed this bit
logic                   ws_fall;                        // ws went 1 to 0
logic                   run_bit;                        // Bit taken this cycle
logic                   lsb_bit;                        // Bit taken is the LSB
logic [CNT_W-1:0]       bit_cnt;                        // Bits taken in current word
logic                   word_ch;                        // Channel of current word
logic [SAMPLE_W-1:0]    shift_reg;                      // MSB first shifter
logic [SAMPLE_W-1:0]    word_next;                      // Shifter with new bit

assign ws_edge   = ws_s ^ ws_prev;
assign ws_fall   = ws_prev & ~ws_s;
assign run_bit   = rx_en && (state == ST_RUN) && sck_rise;
assign lsb_bit   = (bit_cnt == CNT_W'(SAMPLE_W - 1));
assign word_next = {shift_reg[SAMPLE_W-2:0], sd_s};

//////////////////////////////////////////////////
// Enable, start and bit count
//////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        state     <= ST_IDLE;
        ws_prev   <= 1'b0;
        bit_cnt   <= '0;
        word_ch   <= 1'b0;
        rx_strobe <= 1'b0;
    end
    else
    begin
        rx_strobe <= 1'b0;                              // Single cycle pulse
        if (sck_rise)
            ws_prev <= ws_s;                            // Tracked even when idle
        if (!rx_en)
            state <= ST_IDLE;                           // Partial frame dropped
        else
        begin
            case (state)
                ST_IDLE:
                    state <= ST_WAIT;
                ST_WAIT:
                    if (sck_rise && ws_fall)
                    begin
                        state   <= ST_RUN;              // Next bit is left MSB
                        bit_cnt <= '0;
                    end
                ST_RUN:
                    if (sck_rise)
                    begin
                        if (bit_cnt == '0)
                            word_ch <= ws_s;            // ws is stable over the word
                        if (lsb_bit)
                            rx_strobe <= word_ch;       // Right word ends the frame
                        if (ws_edge)
                            bit_cnt <= '0;              // MSB follows a ws change
                        else if (bit_cnt != CNT_W'(SAMPLE_W))
                            bit_cnt <= bit_cnt + 1'b1;  // Hold after the LSB
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end
end

//////////////////////////////////////////////////
// Sample capture
//////////////////////////////////////////////////

always_ff @(posedge clk)
begin
    if (run_bit)
    begin
        shift_reg <= word_next;
        if (lsb_bit)
        begin
            if (word_ch)
                rx_frame.right <= word_next;
            else
                rx_frame.left <= word_next;
        end
    end
end

endmodule

`default_nettype wire

/* logic/i2s_in.sv */
`default_nettype none
`timescale 1ns/100ps

module i2s_in import i2s_cfg_pkg::*, i2s_stream_pkg::*; #(
    parameter int FIFO_DEPTH_LOG2 = FIFO_DEPTH_LOG2_DEF, // log2 of buffered frames
    parameter int RAMP_PERIOD     = RAMP_PERIOD_DEF      // clk cycles per ramp frame
) (
    input  logic        clk,                            // System clock
    input  logic        rst,                            // Async reset, active low
    input  logic        i2s_sck,                        // I2S bit clock
    input  logic        i2s_ws,                         // I2S word select, 0 is left
    input  logic        i2s_sd,                         // I2S serial data, MSB first
    input  logic        rx_en,                          // Serial receiver enable
    input  logic        bist_en,                        // Ramp replaces serial input
    input  ramp_val_t   bist_start,                     // Ramp start value
    input  ramp_val_t   bist_limit,                     // Ramp upper limit
    input  ramp_inc_t   bist_inc,                       // Ramp step
    input  logic        overrun_clr,                    // Clears overrun
    output frame_t      out_data,                       // Stereo frame out
    output logic        out_valid,                      // Frame available
    input  logic        out_ready,                      // Consumer ready
    output logic        overrun                         // Sticky, a frame was lost
);

localparam int SAMPLE_W = $bits(sample_t);

logic       sck_rise;                                   // Synced bit clock edge
logic       ws_s;                                       // Synced word select
logic       sd_s;                                       // Synced serial data
frame_t     rx_frame;                                   // Serial path frame
logic       rx_strobe;
frame_t     ramp_frame;                                 // Self-test frame
logic       ramp_strobe;
frame_t     src_frame;                                  // Selected source
logic       src_strobe;
logic       in_ready;                                   // FIFO has room
logic       drop;                                       // Frame lost to a full FIFO

//////////////////////////////////////////////////
// Frame sources
//////////////////////////////////////////////////

i2s_pin_sync pin_sync_i (
    .clk            (clk),
    .rst            (rst),
    .i2s_sck        (i2s_sck),
    .i2s_ws         (i2s_ws),
    .i2s_sd         (i2s_sd),
    .sck_rise       (sck_rise),
    .ws_s           (ws_s),
    .sd_s           (sd_s)
);

i2s_deserializer #(
    .SAMPLE_W       (SAMPLE_W)
) deser_i (
    .clk            (clk),
    .rst            (rst),
    .sck_rise       (sck_rise),
    .ws_s           (ws_s),
    .sd_s           (sd_s),
    .rx_en          (rx_en),
    .rx_frame       (rx_frame),
    .rx_strobe      (rx_strobe)
);

i2s_ramp_gen #(
    .RAMP_PERIOD    (RAMP_PERIOD)
) ramp_i (
    .clk            (clk),
    .rst            (rst),
    .bist_en        (bist_en),
    .bist_start     (bist_start),
    .bist_limit     (bist_limit),
    .bist_inc       (bist_inc),
    .ramp_frame     (ramp_frame),
    .ramp_strobe    (ramp_strobe)
);

// Source select, neither source can stall
assign src_frame  = bist_en ? ramp_frame  : rx_frame;
assign src_strobe = bist_en ? ramp_strobe : rx_strobe;
assign drop       = src_strobe & ~in_ready;

//////////////////////////////////////////////////
// Buffer and overrun status
//////////////////////////////////////////////////

sample_fifo #(
    .T              (frame_t),
    .DEPTH_LOG2     (FIFO_DEPTH_LOG2)
) fifo_i (
    .clk            (clk),
    .rst            (rst),
    .in_data        (src_frame),
    .in_valid       (src_strobe),
    .in_ready       (in_ready),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_ready      (out_ready)
);

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
        overrun <= 1'b0;
    else if (drop)
        overrun <= 1'b1;                                // Set beats a same-cycle clear
    else if (overrun_clr)
        overrun <= 1'b0;
end

endmodule

`default_nettype wire

/* logic/i2s_pin_sync.sv */
`default_nettype none
`timescale 1ns/100ps

module i2s_pin_sync (
    input  logic    clk,                                // System clock
    input  logic    rst,                                // Async reset, active low
    input  logic    i2s_sck,                            // Bit clock pin, async
    input  logic    i2s_ws,                             // Word select pin, async
    input  logic    i2s_sd,                             // Serial data pin, async
    output logic    sck_rise,                           // One clk per rising sck
    output logic    ws_s,                               // ws aligned to sck_rise
    output logic    sd_s                                // sd aligned to sck_rise
);

// The bit clock must stay high and low for about three clk periods each
// so that every rising edge survives the two flop stages

logic [2:0]     pin_meta;                               // Stage 1 {sck, ws, sd}
logic [2:0]     pin_sync;                               // Stage 2 {sck, ws, sd}
logic           sck_d;                                  // Previous synced sck

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        pin_meta <= '0;
        pin_sync <= '0;
        sck_d    <= 1'b0;
        sck_rise <= 1'b0;
        ws_s     <= 1'b0;
        sd_s     <= 1'b0;
    end
    else
    begin
        pin_meta <= {i2s_sck, i2s_ws, i2s_sd};          // May go metastable
        pin_sync <= pin_meta;                           // Settled copy
        sck_d    <= pin_sync[2];
        sck_rise <= pin_sync[2] & ~sck_d;               // Low to high seen
        ws_s     <= pin_sync[1];                        // Third stage keeps alignment
        sd_s     <= pin_sync[0];
    end
end

endmodule

`default_nettype wire

/* logic/i2s_ramp_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module i2s_ramp_gen import i2s_cfg_pkg::*, i2s_stream_pkg::*; #(
    parameter int RAMP_PERIOD = RAMP_PERIOD_DEF         // clk cycles per frame
) (
    input  logic        clk,                            // System clock
    input  logic        rst,                            // Async reset, active low
    input  logic        bist_en,                        // Run the sawtooth
    input  ramp_val_t   bist_start,                     // First and reload value
    input  ramp_val_t   bist_limit,                     // Highest value emitted
    input  ramp_inc_t   bist_inc,                       // Step per frame
    output frame_t      ramp_frame,                     // Both channels equal
    output logic        ramp_strobe                     // One pulse per period
);

localparam int VAL_W = $bits(ramp_val_t);
localparam int CNT_W = (RAMP_PERIOD > 1) ? $clog2(RAMP_PERIOD) : 1;

logic [CNT_W-1:0]   period_cnt;                         // Cycles into the period
logic               period_end;                         // Last cycle of the period
ramp_val_t          ramp_val;                           // Value of the next frame
logic [VAL_W:0]     ramp_sum;                           // One carry bit for the wrap test

assign period_end = (period_cnt == CNT_W'(RAMP_PERIOD - 1));
assign ramp_sum   = {1'b0, ramp_val} + (VAL_W + 1)'(bist_inc);

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        period_cnt  <= '0;
        ramp_val    <= '0;
        ramp_strobe <= 1'b0;
    end
    else if (!bist_en)
    begin
        period_cnt  <= '0;
        ramp_val    <= bist_start;                      // Preload for the next run
        ramp_strobe <= 1'b0;
    end
    else
    begin
        ramp_strobe <= period_end;
        if (period_end)
        begin
            period_cnt <= '0;
            if (ramp_sum > {1'b0, bist_limit})
                ramp_val <= bist_start;                 // Sawtooth wrap
            else
                ramp_val <= ramp_sum[VAL_W-1:0];
        end
        else
            period_cnt <= period_cnt + 1'b1;
    end
end

// Payload loads with the strobe
always_ff @(posedge clk)
begin
    if (bist_en && period_end)
    begin
        ramp_frame.left  <= sample_t'(ramp_val);        // Zero extended
        ramp_frame.right <= sample_t'(ramp_val);
    end
end

endmodule

`default_nettype wire

/* logic/i2s_stream_pkg.sv */
`default_nettype none

package i2s_stream_pkg;

    // One PCM sample, two's complement from the converter
    typedef logic [15:0] sample_t;

    // Stereo frame, left in the upper half
    typedef struct packed {
        sample_t left;                                  // Channel sent with ws low
        sample_t right;                                 // Channel sent with ws high
    } frame_t;

endpackage

`default_nettype wire

/* logic/sample_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module sample_fifo #(
    parameter type T          = logic [31:0],           // Payload type
    parameter int  DEPTH_LOG2 = 3                       // log2 of entries, at least 1
) (
    input  logic    clk,                                // System clock
    input  logic    rst,                                // Async reset, active low
    input  T        in_data,                            // Write payload
    input  logic    in_valid,                           // Write request
    output logic    in_ready,                           // Not full
    output T        out_data,                           // Head of queue, registered
    output logic    out_valid,                          // Head is present
    input  logic    out_ready                           // Consumer takes head
);

localparam int DEPTH = 2 ** DEPTH_LOG2;

T                       mem [DEPTH];                    // Circular storage
logic [DEPTH_LOG2:0]    wr_ptr;                         // Extra MSB tells full from empty
logic [DEPTH_LOG2:0]    rd_ptr;                         // Points at the head entry
logic [DEPTH_LOG2:0]    wr_ptr_nxt;
logic [DEPTH_LOG2:0]    rd_ptr_nxt;
logic                   full;
logic                   push;                           // Write accepted
logic                   pop;                            // Head handed over
logic                   bypass;                         // Write goes straight to head

// Head stays counted in mem until popped, so the output register adds no slot
assign full       = (wr_ptr == (rd_ptr ^ {1'b1, {DEPTH_LOG2{1'b0}}}));
assign in_ready   = ~full;
assign push       = in_valid & ~full;
assign pop        = out_valid & out_ready;
assign wr_ptr_nxt = wr_ptr + {{DEPTH_LOG2{1'b0}}, push};
assign rd_ptr_nxt = rd_ptr + {{DEPTH_LOG2{1'b0}}, pop};
assign bypass     = push && (wr_ptr == rd_ptr_nxt);     // Queue empty after this pop

//////////////////////////////////////////////////
// Pointers and output valid
//////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        wr_ptr    <= '0;
        rd_ptr    <= '0;
        out_valid <= 1'b0;
    end
    else
    begin
        wr_ptr    <= wr_ptr_nxt;
        rd_ptr    <= rd_ptr_nxt;
        out_valid <= (wr_ptr_nxt != rd_ptr_nxt);        // Anything left after this edge
    end
end

//////////////////////////////////////////////////
// Storage and show-ahead head register
//////////////////////////////////////////////////

always_ff @(posedge clk)
begin
    if (push)
        mem[wr_ptr[DEPTH_LOG2-1:0]] <= in_data;
    if (bypass)
        out_data <= in_data;
    else
        out_data <= mem[rd_ptr_nxt[DEPTH_LOG2-1:0]];   // Reload keeps held head stable
end

endmodule

`default_nettype wire

/* project.f */
logic/i2s_cfg_pkg.sv
logic/i2s_stream_pkg.sv
logic/i2s_pin_sync.sv
logic/i2s_deserializer.sv
logic/i2s_ramp_gen.sv
logic/sample_fifo.sv
logic/i2s_in.sv
sim/i2s_in_tb.sv

/* sim/i2s_in_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module i2s_in_tb import i2s_cfg_pkg::*, i2s_stream_pkg::*; ();

localparam int FIFO_DEPTH_LOG2 = FIFO_DEPTH_LOG2_DEF;
localparam int DEPTH       = 2 ** FIFO_DEPTH_LOG2;
localparam int RAMP_PERIOD = 32;                        // Shorter than default, keeps run brief
localparam int SAMPLE_W    = $bits(sample_t);
localparam int FRAME_W     = $bits(frame_t);
localparam int SCK_HALF    = 4;                         // clk cycles per sck phase
localparam int FRAME_CYC   = FRAME_W * 2 * SCK_HALF;    // clk cycles per serial frame
localparam int N_RAND      = 40;
localparam int N_SWITCH    = 4;
localparam int N_RAMP_A    = 16;
localparam int N_RAMP_B    = 8;
localparam int N_SERIAL    = 3 + N_RAND + (DEPTH + 2) + N_SWITCH;
localparam int TIMEOUT     = N_SERIAL * FRAME_CYC + (N_RAMP_A + N_RAMP_B) * RAMP_PERIOD + 2000;

logic       clk = 1'b0;
logic       rst = 1'b0;                                 // Held in reset from time zero
logic       i2s_sck = 1'b0;
logic       i2s_ws = 1'b0;
logic       i2s_sd = 1'b0;
logic       rx_en = 1'b0;
logic       bist_en = 1'b0;
ramp_val_t  bist_start = '0;
ramp_val_t  bist_limit = '0;
ramp_inc_t  bist_inc = '0;
logic       overrun_clr = 1'b0;
logic       out_ready = 1'b0;
frame_t     out_data;
logic       out_valid;
logic       overrun;

frame_t         exp_q [$];                              // Frames the DUT must deliver, in order
frame_t         head_f;
integer         seed = 32'h31649741;                    // Serial payload
integer         ready_seed = 32'h31649741;              // Consumer stalls
integer         rnd;
int unsigned    cycle_cnt = 0;
logic [1:0]     ready_mode = 2'd0;                      // 0 random, 1 always high, 2 held low

i2s_in #(
    .FIFO_DEPTH_LOG2    (FIFO_DEPTH_LOG2),
    .RAMP_PERIOD        (RAMP_PERIOD)
) dut_i (.*);

always #5 clk = ~clk;                                   // 100 MHz

//////////////////////////////////////////////////
// Checking and failure
//////////////////////////////////////////////////

task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at first error");
endtask

task automatic check_frame(input frame_t got, input frame_t exp, input string what);
    if (got !== exp)
        stop_run($sformatf("mismatch at %0d ns: %s, got L=%h R=%h, expected L=%h R=%h",
                           $time, what, got.left, got.right, exp.left, exp.right));
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
        stop_run($sformatf("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp));
endtask

//////////////////////////////////////////////////
// Stimulus models
//////////////////////////////////////////////////

function automatic frame_t random_frame();
    random_frame = $random(seed);                       // Left in upper half
endfunction

function automatic frame_t make_ramp_frame(input ramp_val_t v);
    frame_t f;
    f.left  = sample_t'(v);                             // Zero extended
    f.right = sample_t'(v);
    return f;
endfunction

// Sawtooth step, wraps to start when the sum passes the limit
function automatic ramp_val_t advance_ramp(input ramp_val_t v, input ramp_val_t start,
                                           input ramp_val_t limit, input ramp_inc_t inc);
    logic [$bits(ramp_val_t):0] sum;
    sum = v + inc;                                      // Carry kept for the compare
    return (sum > limit) ? start : sum[$bits(ramp_val_t)-1:0];
endfunction

// I2S word: ws leads the MSB by one bit, data changes while sck is low
task automatic send_frame(input frame_t f, input logic expect_it);
    logic [FRAME_W-1:0] word;
    int i;
    word = f;
    if (expect_it && exp_q.size() < DEPTH)
        exp_q.push_back(f);                             // Room predicted in the FIFO
    for (i = 0; i < FRAME_W; i++)
    begin
        i2s_sck <= 1'b0;
        i2s_ws  <= (i >= SAMPLE_W - 1) && (i < FRAME_W - 1);
        i2s_sd  <= word[FRAME_W - 1 - i];
        repeat (SCK_HALF) @(posedge clk);
        i2s_sck <= 1'b1;                                // Receiver samples here
        repeat (SCK_HALF) @(posedge clk);
    end
endtask

task automatic wait_drained();
    while (exp_q.size() != 0)
        @(posedge clk);
    repeat (2) @(posedge clk);                          // Let out_valid fall
endtask

task automatic run_ramp(input ramp_val_t start, input ramp_val_t limit,
                        input ramp_inc_t inc, input int n);
    ramp_val_t v;
    int i;
    bist_start <= start;
    bist_limit <= limit;
    bist_inc   <= inc;
    ready_mode <= 2'd1;
    v = start;
    for (i = 0; i < n; i++)
    begin
        exp_q.push_back(make_ramp_frame(v));
        v = advance_ramp(v, start, limit, inc);
    end
    repeat (2) @(posedge clk);                          // Generator preloads start
    bist_en <= 1'b1;
    wait_drained();
    bist_en <= 1'b0;                                    // Well before the next strobe
    ready_mode <= 2'd0;
endtask

//////////////////////////////////////////////////
// Consumer, monitor and timeout
//////////////////////////////////////////////////

always @(posedge clk)
begin
    rnd = $random(ready_seed);
    if (ready_mode == 2'd2)
        out_ready <= 1'b0;
    else if (ready_mode == 2'd1 || exp_q.size() >= DEPTH - 1)
        out_ready <= 1'b1;                              // Slack near the full boundary
    else
        out_ready <= rnd[0];
end

always @(posedge clk)
begin
    if (rst && out_valid && out_ready)
    begin
        if (exp_q.size() == 0)
            stop_run($sformatf("Unexpected frame delivered at %0d ns", $time));
        else
        begin
            head_f = exp_q.pop_front();
            check_frame(out_data, head_f, "output frame");
        end
    end
end

always @(posedge clk)
begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT)
        stop_run($sformatf("Timeout: the test did not finish within %0d cycles", TIMEOUT));
end

//////////////////////////////////////////////////
// Test sequence
//////////////////////////////////////////////////

initial
begin
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(overrun, 1'b0, "overrun after reset");
    repeat (2) send_frame(random_frame(), 1'b0);        // Receiver disabled
    fork
        send_frame(random_frame(), 1'b0);               // Partial, enable lands mid frame
        begin
            repeat (8 * 2 * SCK_HALF) @(posedge clk);
            rx_en <= 1'b1;
        end
    join
    repeat (N_RAND) send_frame(random_frame(), 1'b1);   // First full frame after ws fall
    wait_drained();
    check_flag(overrun, 1'b0, "overrun after serial run");
    ready_mode <= 2'd2;                                 // Consumer stalls
    repeat (DEPTH) send_frame(random_frame(), 1'b1);
    repeat (8) @(posedge clk);
    check_flag(overrun, 1'b0, "overrun with FIFO just full");
    send_frame(random_frame(), 1'b1);                   // Dropped
    repeat (8) @(posedge clk);
    check_flag(overrun, 1'b1, "overrun after first drop");
    send_frame(random_frame(), 1'b1);
    repeat (8) @(posedge clk);
    check_flag(overrun, 1'b1, "overrun after second drop");
    ready_mode <= 2'd0;
    wait_drained();
    check_flag(overrun, 1'b1, "overrun after drain");
    overrun_clr <= 1'b1;
    @(posedge clk);
    overrun_clr <= 1'b0;
    repeat (2) @(posedge clk);
    check_flag(overrun, 1'b0, "overrun after clear");
    run_ramp(12'h100, 12'h220, 8'h40, N_RAMP_A);        // Wraps every five frames
    repeat (N_SWITCH) send_frame(random_frame(), 1'b1); // Back to serial
    wait_drained();
    run_ramp(12'hf80, 12'hfff, 8'h30, N_RAMP_B);        // Sum carries past 12 bits
    repeat (16) @(posedge clk);
    check_flag(overrun, 1'b0, "overrun at end");
    if (exp_q.size() == 0)
    begin
        $display("All checks passed");
        $finish;
    end
    else
        stop_run("Expected frames were never delivered");
end

endmodule

`default_nettype wire
